// File: design/dsp_types_pkg.sv
/*
 * dsp types package
 * sample widths and the complex sample word used on every datapath
 */
`default_nettype none

package dsp_types_pkg;

  // ----------------------------------------------------------------------
  // sample format
  // ----------------------------------------------------------------------

  // width of one I or Q component
  localparam int IQ_W = 16;  // two's complement, full scale +/-1.0

  // one complex baseband sample
  // i sits in the upper half of the packed word, q in the lower half
  typedef struct packed {
    logic signed [IQ_W-1:0] i;  // in-phase
    logic signed [IQ_W-1:0] q;  // quadrature
  } iq_sample_t;

endpackage : dsp_types_pkg

`default_nettype wire

// File: design/timing_pkg.sv
/*
 * timing loop package
 * error, control and phase widths plus the detector error report
 */
`default_nettype none

package timing_pkg;

  // ----------------------------------------------------------------------
  // loop widths
  // ----------------------------------------------------------------------

  localparam int ERR_W  = 18;      // timing error width
  localparam int FRAC_W = 12;      // fractional phase bits, one sample = 2**FRAC_W
  localparam int CTRL_W = FRAC_W;  // signed control word, +/- half a sample per clock

  // control word limits
  localparam logic signed [CTRL_W-1:0] CTRL_MAX = {1'b0, {(CTRL_W-1){1'b1}}};
  localparam logic signed [CTRL_W-1:0] CTRL_MIN = {1'b1, {(CTRL_W-1){1'b0}}};

  // ----------------------------------------------------------------------
  // error report from the detector
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic signed [ERR_W-1:0] err;  // scaled gardner error
    logic                    valid; // one cycle per symbol
  } ted_err_t;

endpackage : timing_pkg

`default_nettype wire

// File: design/gardner_ted.sv
/*
 * gardner timing error detector
 * sample delay line, error from mid and previous symbol taps, symbol capture
 */
`timescale 1ns/100ps
`default_nettype none

module gardner_ted
  import dsp_types_pkg::*, timing_pkg::*;
#(
  parameter int OSF = 20  // samples per symbol, even, >= 4
) (
  input  logic       clk,
  input  logic       reset_n,
  input  iq_sample_t sample_i,      // one sample per clock
  input  logic       sym_strobe_i,  // from nco
  output ted_err_t   err_o,
  output iq_sample_t sym_o,
  output logic       sym_valid_o
);

  localparam int H_TAP  = OSF/2 - 1;                    // mid-symbol delay
  localparam int P_TAP  = OSF - 1;                      // previous symbol delay
  localparam int SHIFT  = IQ_W + $clog2(OSF) - ERR_W;   // scale down to ERR_W
  localparam int DIFF_W = IQ_W + 1;
  localparam int PROD_W = IQ_W + DIFF_W;
  localparam int SUM_W  = PROD_W + 1;

  // ----------------------------------------------------------------------
  // delay line indexed by delay in cycles
  // ----------------------------------------------------------------------
  iq_sample_t dline [1:OSF-1];  // with sample_i this holds the last OSF samples

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int k = 1; k < OSF; k++) begin
        dline[k] <= '0;
      end
    end else begin
      dline[1] <= sample_i;
      for (int k = 2; k < OSF; k++) begin
        dline[k] <= dline[k-1];
      end
    end
  end

  iq_sample_t tap_h, tap_p;
  assign tap_h = dline[H_TAP];
  assign tap_p = dline[P_TAP];

  // ----------------------------------------------------------------------
  // error h.i*(c.i-p.i) + h.q*(c.q-p.q) kept at full width
  // ----------------------------------------------------------------------
  logic signed [DIFF_W-1:0] d_i, d_q;
  logic signed [PROD_W-1:0] prod_i, prod_q;
  logic signed [SUM_W-1:0]  err_sum, err_shr;
  logic signed [ERR_W-1:0]  err_scaled;

  assign d_i = {sample_i.i[IQ_W-1], sample_i.i} - {tap_p.i[IQ_W-1], tap_p.i};  // no overflow
  assign d_q = {sample_i.q[IQ_W-1], sample_i.q} - {tap_p.q[IQ_W-1], tap_p.q};

  assign prod_i  = tap_h.i * d_i;
  assign prod_q  = tap_h.q * d_q;
  assign err_sum = prod_i + prod_q;

  assign err_shr    = err_sum >>> SHIFT;     // arithmetic
  assign err_scaled = err_shr[ERR_W-1:0];    // low bits only so large errors wrap

  // ----------------------------------------------------------------------
  // capture on strobe
  // ----------------------------------------------------------------------
  logic                    err_vld_q;  // error report valid
  logic                    sym_vld_q;  // symbol valid
  logic signed [ERR_W-1:0] err_q;
  iq_sample_t              sym_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      err_vld_q <= 1'b0;
      sym_vld_q <= 1'b0;
    end else begin
      err_vld_q <= sym_strobe_i;  // single cycle pulse
      sym_vld_q <= sym_strobe_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sym_strobe_i) begin
      err_q <= err_scaled;
      sym_q <= sample_i;  // sample present at the strobe
    end
  end

  assign err_o       = '{err: err_q, valid: err_vld_q};
  assign sym_o       = sym_q;
  assign sym_valid_o = sym_vld_q;

endmodule : gardner_ted

`default_nettype wire

// File: design/loop_filter_pi.sv
/*
 * proportional-integral loop filter
 * saturating integrator and control word update on each error report
 */
`timescale 1ns/100ps
`default_nettype none

module loop_filter_pi
  import timing_pkg::*;
#(
  parameter int KP_SHIFT = 4,  // proportional gain 2**-KP_SHIFT
  parameter int KI_SHIFT = 8   // integral gain 2**-KI_SHIFT
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  ted_err_t                 err_i,
  output logic signed [CTRL_W-1:0] ctrl_o
);

  localparam int SUM_W = ERR_W + 1;  // headroom for one add

  // clamp to the control word range
  function automatic logic signed [CTRL_W-1:0] sat_ctrl(input logic signed [SUM_W-1:0] x);
    logic signed [CTRL_W-1:0] y;
    if (x > CTRL_MAX) begin
      y = CTRL_MAX;
    end else if (x < CTRL_MIN) begin
      y = CTRL_MIN;
    end else begin
      y = x[CTRL_W-1:0];
    end
    return y;
  endfunction

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------
  logic signed [ERR_W-1:0]  p_term, i_term;
  logic signed [CTRL_W-1:0] integ, integ_nxt, ctrl_nxt;
  logic signed [SUM_W-1:0]  integ_sum, ctrl_sum;
  logic signed [CTRL_W-1:0] ctrl_q;

  assign p_term = err_i.err >>> KP_SHIFT;  // proportional path
  assign i_term = err_i.err >>> KI_SHIFT;  // integral path

  assign integ_sum = integ + i_term;
  assign integ_nxt = sat_ctrl(integ_sum);  // integrator bounded like ctrl

  assign ctrl_sum = p_term + integ_nxt;    // uses the new integ
  assign ctrl_nxt = sat_ctrl(ctrl_sum);

  // update only on a report, hold otherwise
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      integ  <= '0;
      ctrl_q <= '0;
    end else if (err_i.valid) begin
      integ  <= integ_nxt;
      ctrl_q <= ctrl_nxt;  // visible the cycle after valid
    end
  end

  assign ctrl_o = ctrl_q;

endmodule : loop_filter_pi

`default_nettype wire

// File: design/symbol_nco.sv
/*
 * symbol rate nco
 * modulo phase accumulator that pulses the symbol strobe on each wrap
 */
`timescale 1ns/100ps
`default_nettype none

module symbol_nco
  import timing_pkg::*;
#(
  parameter int OSF = 20  // samples per symbol
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic signed [CTRL_W-1:0] ctrl_i,       // rate correction
  output logic                     sym_strobe_o  // one cycle per symbol
);

  // ----------------------------------------------------------------------
  // phase arithmetic, one sample = STEP
  // ----------------------------------------------------------------------
  localparam int STEP  = 2 ** FRAC_W;      // nominal advance per clock
  localparam int MOD   = OSF * STEP;       // one symbol of phase
  localparam int PH_W  = $clog2(MOD);
  localparam int INC_W = FRAC_W + 1;       // step +/- half a sample stays positive
  localparam int SUM_W = PH_W + 1;

  logic [PH_W-1:0]  phase;
  logic [INC_W-1:0] incr;
  logic [SUM_W-1:0] sum;
  logic             wrap;
  logic             strobe_q;

  assign incr = INC_W'(STEP) + INC_W'(ctrl_i);  // ctrl sign extended
  assign sum  = SUM_W'(phase) + SUM_W'(incr);
  assign wrap = (sum >= SUM_W'(MOD));           // crossing this cycle

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      phase    <= '0;
      strobe_q <= 1'b0;
    end else begin
      if (wrap) begin
        phase <= PH_W'(sum - SUM_W'(MOD));  // modulo subtract
      end else begin
        phase <= PH_W'(sum);
      end
      strobe_q <= wrap;  // one cycle after the crossing update
    end
  end

  assign sym_strobe_o = strobe_q;

endmodule : symbol_nco

`default_nettype wire

// File: design/timing_recovery_top.sv
/*
 * symbol timing recovery top
 * closes the detector, loop filter and nco loop
 */
`timescale 1ns/100ps
`default_nettype none

module timing_recovery_top
  import dsp_types_pkg::*, timing_pkg::*;
#(
  parameter int OSF      = 20,  // samples per symbol
  parameter int KP_SHIFT = 4,   // proportional shift
  parameter int KI_SHIFT = 8    // integral shift
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  iq_sample_t               sample_i,    // valid every clock
  output iq_sample_t               sym_o,
  output logic                     sym_valid_o,
  output ted_err_t                 err_o,
  output logic signed [CTRL_W-1:0] ctrl_o
);

  // ----------------------------------------------------------------------
  // loop signals
  // ----------------------------------------------------------------------
  logic                     sym_strobe;  // nco -> detector
  ted_err_t                 err;         // detector -> filter
  logic signed [CTRL_W-1:0] ctrl;        // filter -> nco

  gardner_ted #(
    .OSF (OSF)
  ) u_ted (
    .clk          (clk),
    .reset_n      (reset_n),
    .sample_i     (sample_i),
    .sym_strobe_i (sym_strobe),
    .err_o        (err),
    .sym_o        (sym_o),
    .sym_valid_o  (sym_valid_o)
  );

  loop_filter_pi #(
    .KP_SHIFT (KP_SHIFT),
    .KI_SHIFT (KI_SHIFT)
  ) u_lf (
    .clk     (clk),
    .reset_n (reset_n),
    .err_i   (err),
    .ctrl_o  (ctrl)
  );

  symbol_nco #(
    .OSF (OSF)
  ) u_nco (
    .clk          (clk),
    .reset_n      (reset_n),
    .ctrl_i       (ctrl),
    .sym_strobe_o (sym_strobe)
  );

  assign err_o  = err;   // strobe + 1
  assign ctrl_o = ctrl;  // strobe + 2

endmodule : timing_recovery_top

`default_nettype wire

// File: dv/timing_recovery_sva.sv
/*
 * timing recovery assertions
 * valid pulse pairing, control word hold, reset state
 */
`timescale 1ns/100ps
`default_nettype none

module timing_recovery_sva
  import timing_pkg::*;
(
  input logic                     clk,
  input logic                     reset_n,
  input logic                     sym_valid_o,
  input ted_err_t                 err_o,
  input logic signed [CTRL_W-1:0] ctrl_o
);

  // ----------------------------------------------------------------------
  // symbol and error reports
  // ----------------------------------------------------------------------
  a_valid_pair: assert property (@(posedge clk) disable iff (!reset_n)
    err_o.valid == sym_valid_o)
    else $error("err_o.valid and sym_valid_o disagree");

  a_valid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    sym_valid_o |=> !sym_valid_o)  // one cycle per symbol
    else $error("sym_valid_o held for more than one cycle");

  // control word known and only moved by an error report
  a_ctrl_known: assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown(ctrl_o))
    else $error("ctrl_o unknown");

  a_ctrl_hold: assert property (@(posedge clk) disable iff (!reset_n)
    !$past(err_o.valid) |-> ctrl_o == $past(ctrl_o))  // held between reports
    else $error("ctrl_o changed without an error report");

  a_reset_quiet: assert property (@(posedge clk)
    !reset_n |=> !sym_valid_o && !err_o.valid)
    else $error("valid output high during reset");

endmodule : timing_recovery_sva

bind timing_recovery_top timing_recovery_sva u_sva (
  .clk         (clk),
  .reset_n     (reset_n),
  .sym_valid_o (sym_valid_o),
  .err_o       (err_o),
  .ctrl_o      (ctrl_o)
);

`default_nettype wire

// File: dv/timing_recovery_tb.sv
/*
 * timing recovery testbench
 * table driven stimulus, cycle exact reference loop and output compares
 */
`timescale 1ns/100ps
`default_nettype none

module timing_recovery_tb
  import dsp_types_pkg::*, timing_pkg::*;
();

  localparam int OSF       = 20;
  localparam int KP_SHIFT  = 4;
  localparam int KI_SHIFT  = 8;
  localparam int STEP      = 2 ** FRAC_W;                    // one sample of phase
  localparam int MODULUS   = OSF * STEP;
  localparam int H_DLY     = OSF/2 - 1;                      // mid-symbol tap
  localparam int P_DLY     = OSF - 1;                        // previous symbol tap
  localparam int ERR_SHIFT = IQ_W + $clog2(OSF) - ERR_W;
  localparam int CMAX      = 2 ** (CTRL_W-1) - 1;
  localparam int CMIN      = -(2 ** (CTRL_W-1));

  // ----------------------------------------------------------------------
  // stimulus table with one row per waveform segment
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {WAVE_CONST, WAVE_ALT, WAVE_NOISE} wave_t;
  typedef struct packed {
    wave_t                  kind;
    logic signed [IQ_W-1:0] amp;
    logic [15:0]            nsym;  // length in symbols
  } stim_row_t;

  localparam int NROWS = 5;
  stim_row_t rows [NROWS] = '{
    '{WAVE_CONST, 16'sd1000,   16'd6},
    '{WAVE_ALT,   16'sd400,    16'd24},  // error fits and pushes ctrl hard
    '{WAVE_ALT,   16'sd12000,  16'd16},  // error wraps in ERR_W
    '{WAVE_NOISE, 16'sd500,    16'd30},
    '{WAVE_CONST, -16'sd700,   16'd10}
  };

  logic                     clk, reset_n;
  iq_sample_t               sample_i, sym_o;
  logic                     sym_valid_o;
  ted_err_t                 err_o;
  logic signed [CTRL_W-1:0] ctrl_o;

  timing_recovery_top #(.OSF(OSF), .KP_SHIFT(KP_SHIFT), .KI_SHIFT(KI_SHIFT)) uut (
    .clk(clk), .reset_n(reset_n), .sample_i(sample_i), .sym_o(sym_o),
    .sym_valid_o(sym_valid_o), .err_o(err_o), .ctrl_o(ctrl_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // reference loop state as the DUT holds it after each posedge
  iq_sample_t  m_dline [1:OSF-1];
  int          m_phase, m_integ, m_ctrl;
  logic        m_strobe;
  ted_err_t    m_err;
  iq_sample_t  m_sym;
  logic [15:0] lfsr = 16'd7;
  int          cyc, last_vld, first_vld, cur_row;
  wave_t       cur_kind;
  logic        gap_moved;  // noisy segment left the nominal spacing
  logic        sat_seen;   // control word reached a limit

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_iq(input string name, input iq_sample_t got, input iq_sample_t exp);
    if (got !== exp) stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_err(input string name, input ted_err_t got, input ted_err_t exp);
    if (got.valid !== exp.valid)
      stop_run($sformatf("** Error: %s.valid got 0x%h expected 0x%h", name, got.valid, exp.valid));
    else if (exp.valid && got.err !== exp.err)
      stop_run($sformatf("** Error: %s.err got 0x%h expected 0x%h", name, got.err, exp.err));
  endtask

  task automatic check_ctrl(input string name, input logic signed [CTRL_W-1:0] got,
                            input logic signed [CTRL_W-1:0] exp);
    if (got !== exp) stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) stop_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // galois lfsr with taps x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_noise(output int val);
    logic [7:0] b;
    for (int k = 0; k < 8; k++) begin
      b[k] = lfsr[0];  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    val = int'($signed(b));
  endtask

  task automatic make_sample(input stim_row_t r, input int t, output iq_sample_t s);
    int sgn, vi, vq, ni, nq;
    sgn = (r.kind != WAVE_CONST && ((t / OSF) % 2 == 1)) ? -1 : 1;  // flips each symbol
    vi  = sgn * int'(r.amp);
    vq  = -sgn * (int'(r.amp) / 2);
    if (r.kind == WAVE_NOISE) begin
      draw_noise(ni);
      draw_noise(nq);
      vi += ni;
      vq += nq;
    end
    s.i = vi[IQ_W-1:0];
    s.q = vq[IQ_W-1:0];
  endtask

  function automatic int clamp_ctrl(input int x);
    return (x > CMAX) ? CMAX : (x < CMIN) ? CMIN : x;
  endfunction

  // h.i*(c.i-p.i) + h.q*(c.q-p.q) shifted with low ERR_W bits kept
  function automatic logic signed [ERR_W-1:0] gardner_err(input iq_sample_t c, h, p);
    longint acc;
    acc = longint'(h.i) * (longint'(c.i) - longint'(p.i))
        + longint'(h.q) * (longint'(c.q) - longint'(p.q));
    acc = acc >>> ERR_SHIFT;
    return acc[ERR_W-1:0];
  endfunction

  // ----------------------------------------------------------------------
  // one clock of the reference loop with all updates from old state
  // ----------------------------------------------------------------------
  task automatic model_step(input iq_sample_t s);
    ted_err_t   n_err;
    iq_sample_t n_sym;
    int         n_integ, n_ctrl, sum, e;
    n_err = '{err: m_err.err, valid: m_strobe};
    n_sym = m_sym;
    if (m_strobe) begin
      n_err.err = gardner_err(s, m_dline[H_DLY], m_dline[P_DLY]);
      n_sym     = s;
    end
    n_integ = m_integ;
    n_ctrl  = m_ctrl;  // held between reports
    if (m_err.valid) begin
      e       = m_err.err;
      n_integ = clamp_ctrl(m_integ + (e >>> KI_SHIFT));
      n_ctrl  = clamp_ctrl((e >>> KP_SHIFT) + n_integ);
    end
    sum      = m_phase + STEP + m_ctrl;  // old ctrl steers this cycle
    m_strobe = (sum >= MODULUS);
    m_phase  = m_strobe ? sum - MODULUS : sum;
    for (int k = OSF-1; k > 1; k--) m_dline[k] = m_dline[k-1];
    m_dline[1] = s;
    m_err   = n_err;
    m_sym   = n_sym;
    m_integ = n_integ;
    m_ctrl  = n_ctrl;
  endtask

  task automatic note_symbol();
    int gap;
    gap = cyc - last_vld;
    if (first_vld == 0) begin
      first_vld = cyc;
      if (cyc != OSF + 1)
        stop_run($sformatf("first symbol came %0d cycles after reset, not %0d", cyc, OSF + 1));
    end else begin
      if (cur_kind == WAVE_NOISE && gap != OSF) gap_moved = 1'b1;
      if (cur_row == 0 && gap != OSF) stop_run("symbols under constant input are not OSF apart");
    end
    if (cur_row == 0) begin  // constant input gives no timing error at all
      check_err("err_o", err_o, '{err: '0, valid: 1'b1});
      check_ctrl("ctrl_o", ctrl_o, '0);
    end
    last_vld = cyc;
  endtask

  task automatic run_cycle(input iq_sample_t s);
    sample_i = s;
    model_step(s);
    @(negedge clk);  // registered outputs settled
    cyc++;
    check_flag("sym_valid_o", sym_valid_o, m_err.valid);
    check_err("err_o", err_o, m_err);
    check_ctrl("ctrl_o", ctrl_o, CTRL_W'(m_ctrl));
    if (m_ctrl == CMAX || m_ctrl == CMIN) sat_seen = 1'b1;
    if (m_err.valid) begin
      check_iq("sym_o", sym_o, m_sym);
      note_symbol();
    end
  endtask

  initial begin
    iq_sample_t s;
    reset_n  = 1'b0;
    sample_i = '0;
    for (int k = 1; k < OSF; k++) m_dline[k] = '0;
    {m_phase, m_integ, m_ctrl, cyc, last_vld, first_vld} = '0;
    {m_strobe, gap_moved, sat_seen} = '0;
    m_err = '0;
    m_sym = '0;
    repeat (5) begin
      @(negedge clk);
      check_flag("sym_valid_o", sym_valid_o, 1'b0);
      check_flag("err_o.valid", err_o.valid, 1'b0);
      check_ctrl("ctrl_o", ctrl_o, '0);
    end
    reset_n = 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      cur_row  = r;
      cur_kind = rows[r].kind;
      for (int t = 0; t < int'(rows[r].nsym) * OSF; t++) begin
        make_sample(rows[r], t, s);
        run_cycle(s);
      end
    end
    if (!gap_moved) begin
      stop_run("strobe spacing never moved off OSF under noisy input");
    end else if (!sat_seen) begin
      stop_run("control word never reached its saturation limit");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  // watchdog at table length in cycles plus margin
  initial begin
    int limit, ticks;
    limit = 100;
    for (int r = 0; r < NROWS; r++) limit += int'(rows[r].nsym) * OSF;
    ticks = 0;
    forever begin
      @(posedge clk);
      ticks++;
      if (ticks >= limit)
        stop_run($sformatf("timeout, test still running after %0d cycles", limit));
    end
  end

endmodule : timing_recovery_tb

`default_nettype wire

// File: filelist.f
design/dsp_types_pkg.sv
design/timing_pkg.sv
design/gardner_ted.sv
design/loop_filter_pi.sv
design/symbol_nco.sv
design/timing_recovery_top.sv
dv/timing_recovery_sva.sv
dv/timing_recovery_tb.sv

// File: Makefile
TOP := timing_recovery_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
